/* source/bus_pkg.sv */
package bus_pkg;

  // bus geometry
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;

  // scratch bank layout
  localparam int NUM_BANKS  = 4;
  localparam int BANK_WORDS = 1024;
  localparam int WORD_IDX_W = $clog2(BANK_WORDS); // 10
  localparam int BANK_IDX_W = $clog2(NUM_BANKS);  // 2

  // address field widths
  localparam int REGION_W = 4;
  localparam int BYTE_W   = 2;
  localparam int ZERO_W   = ADDR_W - REGION_W - BANK_IDX_W - WORD_IDX_W - BYTE_W; // 14

  // region nibble that selects scratch RAM
  localparam logic [REGION_W-1:0] RAM_REGION = 4'h3;

  // decoder controller states
  localparam logic ST_IDLE = 1'b0;
  localparam logic ST_DONE = 1'b1;

  typedef logic [DATA_W-1:0]    bus_word_t;
  typedef logic [NUM_BANKS-1:0] bank_sel_t;
  typedef logic [8*7-1:0]       seg_t; // digit 0 in bits 6:0

  // one bus address seen through both bank layouts
  typedef union packed {
    struct packed {
      logic [REGION_W-1:0]   region;
      logic [ZERO_W-1:0]     zero;
      logic [BANK_IDX_W-1:0] bank;   // contiguous blocks
      logic [WORD_IDX_W-1:0] word;
      logic [BYTE_W-1:0]     offset;
    } lin;
    struct packed {
      logic [REGION_W-1:0]   region;
      logic [ZERO_W-1:0]     zero;
      logic [WORD_IDX_W-1:0] word;
      logic [BANK_IDX_W-1:0] bank;   // rotates every word
      logic [BYTE_W-1:0]     offset;
    } ilv;
  } bus_addr_u;

endpackage

/* source/ram_bank.sv */
`timescale 1ns/10ps

module ram_bank (
  input  logic                           clk,
  input  logic                           we,
  input  logic                           re,
  input  logic [bus_pkg::WORD_IDX_W-1:0] word,
  input  logic [bus_pkg::BE_W-1:0]       be,
  input  bus_pkg::bus_word_t             wdata,
  output bus_pkg::bus_word_t             rdata,
  output logic                           rvalid
);

  bus_pkg::bus_word_t mem [bus_pkg::BANK_WORDS];

  // byte lane writes
  always_ff @(posedge clk) begin
    for (int i = 0; i < bus_pkg::BE_W; i++) begin
      if (we && be[i]) begin
        mem[word][i*8 +: 8] <= wdata[i*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (re) begin
      rdata <= mem[word]; // data holds until the next read
    end
  end

  always_ff @(posedge clk) begin
    rvalid <= re;
  end

  // decoder drives one strobe per request
  we_re_excl: assert property (@(posedge clk) !(we && re));

endmodule

/* source/bus_decoder.sv */
`timescale 1ns/10ps

module bus_decoder (
  input  logic                             clk,
  input  logic                             rst_n,
  input  bus_pkg::bus_addr_u               address,
  input  logic                             read,
  input  logic                             write,
  input  bus_pkg::bus_word_t               writedata,
  input  logic [bus_pkg::BE_W-1:0]         byteenable,
  input  logic                             map,        // 0 linear, 1 interleaved
  output bus_pkg::bank_sel_t               bank_we,
  output bus_pkg::bank_sel_t               bank_re,
  output logic [bus_pkg::WORD_IDX_W-1:0]   bank_word,
  output logic [bus_pkg::BE_W-1:0]         bank_be,
  output bus_pkg::bus_word_t               bank_wdata,
  output logic                             unmapped,
  output logic                             accept,
  output bus_pkg::bus_word_t               accept_addr,
  output logic                             waitrequest
);

  logic                            state;
  logic                            req;
  logic                            valid_addr;
  logic [bus_pkg::BANK_IDX_W-1:0]  bank_idx;
  logic [bus_pkg::WORD_IDX_W-1:0]  word_idx;
  bus_pkg::bank_sel_t              bank_hot;

  assign req = read | write;

  // region and zero field sit at the same place in both views
  assign valid_addr = (address.lin.region == bus_pkg::RAM_REGION) && (address.lin.zero == '0);

  always_comb begin
    if (map) begin
      bank_idx = address.ilv.bank;
      word_idx = address.ilv.word;
    end else begin
      bank_idx = address.lin.bank;
      word_idx = address.lin.word;
    end
  end

  assign bank_hot = bus_pkg::bank_sel_t'(1) << bank_idx;

  assign accept   = (state == bus_pkg::ST_IDLE) && req; // first cycle of a request
  assign unmapped = accept && !valid_addr;

  assign bank_we = (accept && valid_addr && write) ? bank_hot : '0;
  assign bank_re = (accept && valid_addr && read) ? bank_hot : '0;

  assign bank_word   = word_idx;
  assign bank_be     = byteenable;
  assign bank_wdata  = writedata;
  assign accept_addr = address;

  // idle-high wait, released only in the completion cycle
  assign waitrequest = (state == bus_pkg::ST_IDLE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= bus_pkg::ST_IDLE;
    end else if (state == bus_pkg::ST_DONE) begin
      state <= bus_pkg::ST_IDLE;
    end else if (req) begin
      state <= bus_pkg::ST_DONE;
    end
  end

  one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({bank_we, bank_re}));

  no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
    !(read && write));

  // one low cycle per accept, and the cpu still holds the same request in it
  wait_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    accept |=> (!waitrequest && req && $stable(address)) ##1 waitrequest);

endmodule

/* source/read_return.sv */
`timescale 1ns/10ps

module read_return (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  bus_pkg::bus_word_t [bus_pkg::NUM_BANKS-1:0]   rdata,
  input  bus_pkg::bank_sel_t                            rvalid,
  input  logic                                          unmapped,
  input  logic                                          accept,
  output bus_pkg::bus_word_t                            readdata,
  output logic                                          fault
);

  // and-or mux, zero when no bank answers
  always_comb begin
    readdata = '0;
    for (int i = 0; i < bus_pkg::NUM_BANKS; i++) begin
      readdata = readdata | (rdata[i] & {bus_pkg::DATA_W{rvalid[i]}});
    end
  end

  // follows the status of the most recent request
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fault <= 1'b0;
    end else if (accept) begin
      fault <= unmapped;
    end
  end

  rvalid_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(rvalid));

endmodule

/* source/seg_display.sv */
`timescale 1ns/10ps

module seg_display (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               accept,
  input  bus_pkg::bus_word_t accept_addr,
  output bus_pkg::seg_t      seg
);

  bus_pkg::bus_word_t addr_q;

  // segment order g..a, low means lit
  function automatic logic [6:0] hex_to_seg(input logic [3:0] nib);
    case (nib)
      4'h0: return 7'b1000000;
      4'h1: return 7'b1111001;
      4'h2: return 7'b0100100;
      4'h3: return 7'b0110000;
      4'h4: return 7'b0011001;
      4'h5: return 7'b0010010;
      4'h6: return 7'b0000010;
      4'h7: return 7'b1111000;
      4'h8: return 7'b0000000;
      4'h9: return 7'b0010000;
      4'ha: return 7'b0001000;
      4'hb: return 7'b0000011;
      4'hc: return 7'b1000110;
      4'hd: return 7'b0100001;
      4'he: return 7'b0000110;
      default: return 7'b0001110; // F
    endcase
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      addr_q <= '0; // blank bus shows all zeros
    end else if (accept) begin
      addr_q <= accept_addr;
    end
  end

  // digit 7 carries the region nibble
  always_comb begin
    for (int d = 0; d < 8; d++) begin
      seg[d*7 +: 7] = hex_to_seg(addr_q[d*4 +: 4]);
    end
  end

endmodule

/* source/bus_subsystem.sv */
`timescale 1ns/10ps

module bus_subsystem (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [bus_pkg::ADDR_W-1:0]   address,
  input  logic                         read,
  input  logic                         write,
  input  bus_pkg::bus_word_t           writedata,
  input  logic [bus_pkg::BE_W-1:0]     byteenable,
  input  logic                         map,
  output bus_pkg::bus_word_t           readdata,
  output logic                         waitrequest,
  output logic                         fault,
  output bus_pkg::seg_t                seg
);

  bus_pkg::bank_sel_t                           bank_we;
  bus_pkg::bank_sel_t                           bank_re;
  bus_pkg::bank_sel_t                           bank_rvalid;
  logic [bus_pkg::WORD_IDX_W-1:0]               bank_word;
  logic [bus_pkg::BE_W-1:0]                     bank_be;
  bus_pkg::bus_word_t                           bank_wdata;
  bus_pkg::bus_word_t [bus_pkg::NUM_BANKS-1:0]  bank_rdata;
  logic                                         unmapped;
  logic                                         accept;
  bus_pkg::bus_word_t                           accept_addr;

  bus_decoder dec_i (.clk(clk), .rst_n(rst_n), .address(address), .read(read), .write(write),
    .writedata(writedata), .byteenable(byteenable), .map(map), .bank_we(bank_we),
    .bank_re(bank_re), .bank_word(bank_word), .bank_be(bank_be), .bank_wdata(bank_wdata),
    .unmapped(unmapped), .accept(accept), .accept_addr(accept_addr),
    .waitrequest(waitrequest));

  for (genvar g = 0; g < bus_pkg::NUM_BANKS; g++) begin : g_bank
    ram_bank bank_i (.clk(clk), .we(bank_we[g]), .re(bank_re[g]), .word(bank_word),
      .be(bank_be), .wdata(bank_wdata), .rdata(bank_rdata[g]), .rvalid(bank_rvalid[g]));
  end

  read_return ret_i (.clk(clk), .rst_n(rst_n), .rdata(bank_rdata), .rvalid(bank_rvalid),
    .unmapped(unmapped), .accept(accept), .readdata(readdata), .fault(fault));

  seg_display disp_i (.clk(clk), .rst_n(rst_n), .accept(accept), .accept_addr(accept_addr),
    .seg(seg));

endmodule

/* tb/tb_bus_subsystem.sv */
`timescale 1ns/10ps

module tb_bus_subsystem;

  localparam int N_TABLE         = 16;
  localparam int N_RANDOM        = 200;
  localparam int WAIT_LIMIT      = 8;
  localparam int WATCHDOG_CYCLES = (N_TABLE + N_RANDOM) * 20;

  // active-low segments g..a for hex digits 0..f
  localparam logic [6:0] DIGIT_SEG [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
  };

  typedef struct packed {
    logic               wr;
    logic               mp;
    bus_pkg::bus_word_t addr;
    logic [3:0]         be;
    bus_pkg::bus_word_t data;
    logic               fault;
  } xfer_t;

  logic                         clk = 1'b0;
  logic                         rst_n;
  logic [bus_pkg::ADDR_W-1:0]   address;
  logic                         read;
  logic                         write;
  bus_pkg::bus_word_t           writedata;
  logic [bus_pkg::BE_W-1:0]     byteenable;
  logic                         map;
  bus_pkg::bus_word_t           readdata;
  logic                         waitrequest;
  logic                         fault;
  bus_pkg::seg_t                seg;

  xfer_t              stim [N_TABLE];
  bus_pkg::bus_word_t ref_mem [bus_pkg::NUM_BANKS][bus_pkg::BANK_WORDS];
  logic               ref_known [bus_pkg::NUM_BANKS][bus_pkg::BANK_WORDS];
  int                 err_count = 0;
  int                 check_count = 0;
  logic               timed_out = 1'b0;
  logic [31:0]        rng = 32'h7fa7_aabb;

  bus_subsystem dut_i (.clk(clk), .rst_n(rst_n), .address(address), .read(read),
    .write(write), .writedata(writedata), .byteenable(byteenable), .map(map),
    .readdata(readdata), .waitrequest(waitrequest), .fault(fault), .seg(seg));

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic addr_ok(input bus_pkg::bus_word_t addr);
    bus_pkg::bus_addr_u ua;
    ua = addr;
    return (ua.lin.region == bus_pkg::RAM_REGION) && (ua.lin.zero == '0);
  endfunction

  function automatic logic [bus_pkg::BANK_IDX_W-1:0] bank_of(input logic mp,
      input bus_pkg::bus_word_t addr);
    bus_pkg::bus_addr_u ua;
    ua = addr;
    return mp ? ua.ilv.bank : ua.lin.bank;
  endfunction

  function automatic logic [bus_pkg::WORD_IDX_W-1:0] word_of(input logic mp,
      input bus_pkg::bus_word_t addr);
    bus_pkg::bus_addr_u ua;
    ua = addr;
    return mp ? ua.ilv.word : ua.lin.word;
  endfunction

  function automatic bus_pkg::seg_t expected_seg(input bus_pkg::bus_word_t addr);
    bus_pkg::seg_t s;
    for (int d = 0; d < 8; d++) begin
      s[d*7 +: 7] = DIGIT_SEG[addr[d*4 +: 4]];
    end
    return s;
  endfunction

  task automatic check_word(input string name, input bus_pkg::bus_word_t got,
      input bus_pkg::bus_word_t exp);
    check_count++;
    if (got !== exp) begin
      $display("ERR %s: got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_fault(input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      $display("ERR fault: got %h expected %h", got, exp);
      err_count++;
    end
  endtask

  task automatic check_seg(input bus_pkg::seg_t got, input bus_pkg::seg_t exp);
    check_count++;
    if (got !== exp) begin
      $display("ERR seg: got %h expected %h", got, exp);
      err_count++;
    end
  endtask

  task automatic finish_run();
    $display("checks: %0d  errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  // called 1 ns after a rising edge, returns 1 ns after the completion edge
  task automatic run_transfer(input logic wr, input logic mp, input bus_pkg::bus_word_t addr,
      input logic [3:0] be, input bus_pkg::bus_word_t data, input logic exp_fault);
    int                              high_cycles;
    logic                            released;
    logic [bus_pkg::BANK_IDX_W-1:0]  b;
    logic [bus_pkg::WORD_IDX_W-1:0]  w;
    high_cycles = 0;
    released = 1'b0;
    b = bank_of(mp, addr);
    w = word_of(mp, addr);
    address = addr;
    map = mp;
    byteenable = be;
    writedata = data;
    read = !wr;
    write = wr;
    while (!released && high_cycles < WAIT_LIMIT) begin
      @(negedge clk); // outputs settled mid-cycle
      if (waitrequest) begin
        high_cycles++;
      end else begin
        released = 1'b1;
      end
    end
    if (!released) begin
      $display("timeout: waitrequest stayed high for the request at address %h", addr);
      err_count++;
      timed_out = 1'b1;
    end else begin
      check_count++;
      if (high_cycles != 1) begin
        $display("request at address %h waited %0d cycles instead of 1", addr, high_cycles);
        err_count++;
      end
      check_fault(fault, exp_fault);
      check_seg(seg, expected_seg(addr));
      if (exp_fault) begin
        check_word("readdata", readdata, '0);
      end else if (!wr && ref_known[b][w]) begin
        check_word("readdata", readdata, ref_mem[b][w]);
      end
      if (wr && addr_ok(addr)) begin
        for (int i = 0; i < bus_pkg::BE_W; i++) begin
          if (be[i]) begin
            ref_mem[b][w][i*8 +: 8] = data[i*8 +: 8];
          end
        end
        if (be == 4'hf) begin
          ref_known[b][w] = 1'b1;
        end
      end
      @(posedge clk);
      #1;
      read = 1'b0;
      write = 1'b0;
    end
  endtask

  task automatic load_table();
    stim[0]  = '{1'b1, 1'b0, 32'h3000_0100, 4'hf, 32'hdead_beef, 1'b0};
    stim[1]  = '{1'b0, 1'b0, 32'h3000_0100, 4'hf, 32'h0000_0000, 1'b0};
    stim[2]  = '{1'b1, 1'b1, 32'h3000_0204, 4'hf, 32'h1234_5678, 1'b0};
    stim[3]  = '{1'b0, 1'b1, 32'h3000_0204, 4'hf, 32'h0000_0000, 1'b0};
    stim[4]  = '{1'b1, 1'b0, 32'h3000_0100, 4'h5, 32'h1122_3344, 1'b0}; // bytes 0 and 2
    stim[5]  = '{1'b0, 1'b0, 32'h3000_0100, 4'hf, 32'h0000_0000, 1'b0};
    stim[6]  = '{1'b1, 1'b0, 32'h3000_2014, 4'hf, 32'hcafe_f00d, 1'b0}; // bank 2 word 5
    stim[7]  = '{1'b1, 1'b0, 32'h3000_2018, 4'hf, 32'h0bad_cafe, 1'b0}; // bank 2 word 6
    stim[8]  = '{1'b0, 1'b1, 32'h3000_0058, 4'hf, 32'h0000_0000, 1'b0};
    stim[9]  = '{1'b0, 1'b1, 32'h3000_0068, 4'hf, 32'h0000_0000, 1'b0};
    stim[10] = '{1'b1, 1'b0, 32'h4000_2014, 4'hf, 32'hffff_ffff, 1'b1}; // wrong region
    stim[11] = '{1'b0, 1'b0, 32'h3004_2014, 4'hf, 32'h0000_0000, 1'b1}; // zero field set
    stim[12] = '{1'b0, 1'b0, 32'h3000_2014, 4'hf, 32'h0000_0000, 1'b0};
    stim[13] = '{1'b1, 1'b1, 32'h3000_3ffc, 4'hf, 32'ha5a5_a5a5, 1'b0};
    stim[14] = '{1'b0, 1'b0, 32'h3000_3ffc, 4'hf, 32'h0000_0000, 1'b0};
    stim[15] = '{1'b0, 1'b1, 32'h0000_0000, 4'hf, 32'h0000_0000, 1'b1};
  endtask

  initial begin
    bus_pkg::bus_word_t r_addr;
    bus_pkg::bus_word_t r_data;
    logic               r_map;
    logic               r_wr;
    logic [3:0]         r_be;
    rst_n = 1'b0;
    address = '0;
    read = 1'b0;
    write = 1'b0;
    writedata = '0;
    byteenable = '0;
    map = 1'b0;
    for (int b = 0; b < bus_pkg::NUM_BANKS; b++) begin
      for (int w = 0; w < bus_pkg::BANK_WORDS; w++) begin
        ref_known[b][w] = 1'b0;
      end
    end
    load_table();
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_seg(seg, expected_seg('0));
    for (int i = 0; i < N_TABLE && !timed_out; i++) begin
      run_transfer(stim[i].wr, stim[i].mp, stim[i].addr, stim[i].be, stim[i].data,
        stim[i].fault);
    end
    // small window so both layouts hit the same words
    for (int i = 0; i < N_RANDOM && !timed_out; i++) begin
      rng = xorshift(rng);
      r_addr = 32'h3000_0000 | (rng & 32'h0000_303c);
      r_map = rng[20];
      r_wr = rng[21];
      r_be = rng[25:22];
      rng = xorshift(rng);
      r_data = rng;
      if (r_wr && !ref_known[bank_of(r_map, r_addr)][word_of(r_map, r_addr)]) begin
        r_be = 4'hf; // first write fills the whole word
      end
      run_transfer(r_wr, r_map, r_addr, r_be, r_data, !addr_ok(r_addr));
    end
    finish_run();
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    err_count++;
    finish_run();
  end

endmodule

/* filelist.f */
source/bus_pkg.sv
source/ram_bank.sv
source/bus_decoder.sv
source/read_return.sv
source/seg_display.sv
source/bus_subsystem.sv
tb/tb_bus_subsystem.sv

/* Makefile */
# Verilator build of the bus subsystem testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_bus_subsystem \
		-f filelist.f -Mdir obj_dir -o tb_sim
	@out="$$(./obj_dir/tb_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir
